//--- src/cpuDefines_defines.svh
// Width and register-count macros shared by the decode stage, included wherever they are needed
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Data and instruction width
`define XLEN 32

// Register file geometry
`define NREGS 32
`define REGW 5

// Written by call, read by return
`define LINK_REG 1

`endif

//--- src/cpuPkg.sv
// Opcode and sub-unit encodings plus the decoded control word, imported by the decode stage
`include "cpuDefines_defines.svh"

package cpuPkg;

	typedef enum logic [5:0] {
		OP_ADD   = 6'b00_0000, OP_SUB   = 6'b00_0001, OP_LHW   = 6'b00_0010,
		OP_LLW   = 6'b00_0011, OP_AND   = 6'b00_0100, OP_OR    = 6'b00_0101,
		OP_XOR   = 6'b00_0110, OP_NOT   = 6'b00_0111, OP_SLL   = 6'b00_1000,
		OP_SRL   = 6'b00_1001, OP_SRA   = 6'b00_1010, OP_FLUSH = 6'b00_1100,
		OP_BRANCH = 6'b01_0000, OP_CALL = 6'b01_0001, OP_RET   = 6'b01_0010,
		OP_LOAD  = 6'b01_0100, OP_STORE = 6'b01_0101, OP_MULT  = 6'b01_0110,
		OP_DIV   = 6'b01_0111, OP_FADD  = 6'b01_1000, OP_FSUB  = 6'b01_1001,
		OP_FMULT = 6'b01_1010, OP_FDIV  = 6'b01_1011, OP_FTOI  = 6'b01_1100,
		OP_ITOF  = 6'b01_1101, OP_SQRT  = 6'b01_1110, OP_HALT  = 6'b01_1111,
		OP_ENQC  = 6'b10_0000, OP_ENQD  = 6'b10_0100, OP_DEQD  = 6'b10_0101
	} opcodeE;

	typedef enum logic [1:0] {
		EXU_ALU = 2'b00,
		EXU_MDU = 2'b01,
		EXU_FPU = 2'b10
	} exuOpE;

	typedef enum logic [3:0] {
		ALU_ADD = 4'b0000, ALU_SUB = 4'b0001, ALU_LHW = 4'b0010, ALU_LLW = 4'b0011,
		ALU_AND = 4'b0100, ALU_OR  = 4'b0101, ALU_XOR = 4'b0110, ALU_NOT = 4'b0111,
		ALU_SLL = 4'b1000, ALU_SRL = 4'b1001, ALU_SRA = 4'b1010
	} aluOpE;

	typedef enum logic [2:0] {
		FPU_ADD  = 3'b000, FPU_SUB  = 3'b001, FPU_MULT = 3'b010, FPU_DIV = 3'b011,
		FPU_FTOI = 3'b100, FPU_ITOF = 3'b101, FPU_SQRT = 3'b110
	} fpuOpE;

	typedef enum logic [2:0] {
		BR_NEQ = 3'b000, BR_EQ  = 3'b001, BR_GT   = 3'b010, BR_LT    = 3'b011,
		BR_GTE = 3'b100, BR_LTE = 3'b101, BR_OVFL = 3'b110, BR_UNCON = 3'b111
	} branchOpE;

	// Field order is also the order of the flattened top-level outputs
	typedef struct packed {
		logic [`REGW-1:0] rdAddr0;
		logic             rdEn0;
		logic [`REGW-1:0] rdAddr1;
		logic             rdEn1;
		logic [`REGW-1:0] wrAddr;
		logic             wrEn;
		exuOpE            exuOp;
		logic [4:0]       exuShift;
		aluOpE            aluOp;
		logic             mduOp;
		fpuOpE            fpuOp;
		branchOpE         branchOp;
		logic             branch;
		logic             jump;
		logic             call;
		logic             ret;
		logic             aluImm;
		logic             loadHigh;
		logic             memValid;
		logic             memWrite;
		logic             memToReg;
		logic             flush;
		logic             halt;
		logic             npuCfg;
		logic             npuEnq;
		logic             npuDeq;
		logic             zeroEn;
		logic             negativeEn;
		logic             overflowEn;
		logic [25:0]      offset;
	} ctrlWordT;

endpackage

//--- src/regReadIf.sv
// Two register read ports between the decoder side and the register file
`include "cpuDefines_defines.svh"

interface regReadIf;

	logic [`REGW-1:0] addr0;
	logic             en0;
	logic [`REGW-1:0] addr1;
	logic             en1;
	logic [`XLEN-1:0] data0;
	logic [`XLEN-1:0] data1;

	modport reader (output addr0, en0, addr1, en1, input data0, data1);
	modport file (input addr0, en0, addr1, en1, output data0, data1);

endinterface

//--- src/decodeControl.sv
// Combinational decoder that turns one instruction word into the control word for issue
`include "cpuDefines_defines.svh"

module decodeControl (
	input  logic [`XLEN-1:0] instruction,
	output cpuPkg::ctrlWordT ctrl
);
	import cpuPkg::*;

	localparam logic [`REGW-1:0] linkReg = `REGW'(`LINK_REG);

	logic [5:0]       opBits;
	opcodeE           opcode;
	logic [`REGW-1:0] regD;
	logic [`REGW-1:0] regN1;
	logic [`REGW-1:0] regN2;
	logic [4:0]       shiftAmount;
	logic             linkOp;
	logic             memAddrOp;
	logic             flagsOp;

	// Instruction fields
	assign opBits      = instruction[31:26];
	assign opcode      = opcodeE'(opBits);
	assign regD        = instruction[25:21];
	assign regN1       = instruction[20:16];
	assign regN2       = instruction[15:11];
	assign shiftAmount = instruction[4:0];

	assign linkOp    = opcode inside {OP_CALL, OP_RET};
	assign memAddrOp = opcode inside {OP_LOAD, OP_STORE, OP_CALL, OP_RET};

	// Arithmetic, logic, MDU and FPU ops
	assign flagsOp = opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOT,
		OP_SLL, OP_SRL, OP_SRA, OP_MULT, OP_DIV, OP_FADD, OP_FSUB, OP_FMULT,
		OP_FDIV, OP_FTOI, OP_ITOF, OP_SQRT};

	always_comb begin
		ctrl.wrEn = !(opcode inside {OP_FLUSH, OP_BRANCH, OP_STORE, OP_HALT,
			OP_ENQC, OP_ENQD});
		ctrl.wrAddr = linkOp ? linkReg : regD;

		ctrl.rdEn0 = !(opcode inside {OP_LLW, OP_FLUSH, OP_BRANCH, OP_HALT,
			OP_ENQC, OP_DEQD});
		if (opcode inside {OP_LHW, OP_ENQD})
			ctrl.rdAddr0 = regD;
		else if (linkOp)
			ctrl.rdAddr0 = linkReg;
		else
			ctrl.rdAddr0 = regN1;

		ctrl.rdEn1 = !(opcode inside {OP_LHW, OP_LLW, OP_NOT, OP_SLL, OP_SRL, OP_SRA,
			OP_FLUSH, OP_BRANCH, OP_CALL, OP_FTOI, OP_ITOF, OP_SQRT, OP_HALT,
			OP_ENQC, OP_ENQD, OP_DEQD});
		case (opcode)
			OP_STORE: ctrl.rdAddr1 = regD;
			OP_LOAD:  ctrl.rdAddr1 = regN1;
			OP_RET:   ctrl.rdAddr1 = '0;
			default:  ctrl.rdAddr1 = regN2;
		endcase

		// Unit from the opcode group, FPU ops have bit 3 set
		if (opBits[5:4] == 2'b01)
			ctrl.exuOp = opBits[3] ? EXU_FPU : ((opBits[2:1] == 2'b11) ? EXU_MDU : EXU_ALU);
		else
			ctrl.exuOp = EXU_ALU;

		ctrl.exuShift = (opcode inside {OP_SLL, OP_SRL, OP_SRA}) ? shiftAmount : '0;
		// Address generation always adds
		ctrl.aluOp    = memAddrOp ? ALU_ADD : aluOpE'(opBits[3:0]);
		ctrl.mduOp    = opBits[0];
		ctrl.fpuOp    = fpuOpE'(opBits[2:0]);
		ctrl.branchOp = branchOpE'(instruction[25:23]);

		ctrl.branch   = opcode == OP_BRANCH;
		ctrl.jump     = opcode == OP_CALL;
		ctrl.call     = opcode == OP_CALL;
		ctrl.ret      = opcode == OP_RET;
		ctrl.aluImm   = opcode inside {OP_LHW, OP_LLW, OP_LOAD, OP_STORE, OP_ENQC};
		ctrl.loadHigh = opcode == OP_LHW;
		ctrl.memValid = memAddrOp;
		ctrl.memWrite = opcode inside {OP_STORE, OP_CALL};
		ctrl.memToReg = opcode == OP_LOAD;
		ctrl.flush    = opcode == OP_FLUSH;
		ctrl.halt     = opcode == OP_HALT;
		ctrl.npuCfg   = opcode == OP_ENQC;
		ctrl.npuEnq   = opcode == OP_ENQD;
		ctrl.npuDeq   = opcode == OP_DEQD;

		ctrl.zeroEn     = flagsOp;
		ctrl.negativeEn = flagsOp;
		ctrl.overflowEn = flagsOp;
		ctrl.offset     = instruction[25:0];
	end

endmodule

//--- src/registerFile.sv
// General-purpose register file with two read ports, one write-back port and forwarding
`include "cpuDefines_defines.svh"

module registerFile (
	input  logic             clk,
	input  logic             rst,
	input  logic             wbEn,
	input  logic [`REGW-1:0] wbAddr,
	input  logic [`XLEN-1:0] wbData,
	regReadIf.file           rd
);

	logic [`XLEN-1:0] regs [`NREGS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `NREGS; i++)
				regs[i] <= '0;
		end else if (wbEn) begin
			regs[wbAddr] <= wbData;
		end
	end

	// Pending write wins over the stored value
	function automatic logic [`XLEN-1:0] readPort(input logic en, input logic [`REGW-1:0] addr);
		if (!en)
			return '0;
		if (wbEn && (wbAddr == addr))
			return wbData;
		return regs[addr];
	endfunction

	always_comb begin
		rd.data0 = readPort(rd.en0, rd.addr0);
		rd.data1 = readPort(rd.en1, rd.addr1);
	end

endmodule

//--- src/issueRegister.sv
// One-entry valid/ready stage holding decoded controls and operands toward execute
`include "cpuDefines_defines.svh"

module issueRegister (
	input  logic             clk,
	input  logic             rst,
	input  logic             inValid,
	output logic             inReady,
	input  cpuPkg::ctrlWordT ctrlIn,
	input  logic [`XLEN-1:0] op0In,
	input  logic [`XLEN-1:0] op1In,
	output logic             outValid,
	input  logic             outReady,
	output cpuPkg::ctrlWordT ctrlOut,
	output logic [`XLEN-1:0] op0Out,
	output logic [`XLEN-1:0] op1Out
);

	logic accept;

	// Free when empty or drained this cycle
	assign inReady = !outValid || outReady;
	assign accept  = inValid && inReady;

	always_ff @(posedge clk) begin
		if (rst)
			outValid <= 1'b0;
		else if (inReady)
			outValid <= inValid;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			ctrlOut <= ctrlIn;
			op0Out  <= op0In;
			op1Out  <= op1In;
		end
	end

endmodule

//--- src/decodeUnit.sv
// Decode and operand-issue stage top, wiring decoder, register file and issue register
`include "cpuDefines_defines.svh"

module decodeUnit (
	input  logic             clk,
	input  logic             rst,
	input  logic             instValid,
	output logic             instReady,
	input  logic [`XLEN-1:0] instruction,
	input  logic             wbEn,
	input  logic [`REGW-1:0] wbAddr,
	input  logic [`XLEN-1:0] wbData,
	output logic             issueValid,
	input  logic             issueReady,
	output logic [`REGW-1:0] rdAddr0,
	output logic             rdEn0,
	output logic [`REGW-1:0] rdAddr1,
	output logic             rdEn1,
	output logic [`REGW-1:0] wrAddr,
	output logic             wrEn,
	output logic [1:0]       exuOp,
	output logic [4:0]       exuShift,
	output logic [3:0]       aluOp,
	output logic             mduOp,
	output logic [2:0]       fpuOp,
	output logic [2:0]       branchOp,
	output logic             branch,
	output logic             jump,
	output logic             call,
	output logic             ret,
	output logic             aluImm,
	output logic             loadHigh,
	output logic             memValid,
	output logic             memWrite,
	output logic             memToReg,
	output logic             flush,
	output logic             halt,
	output logic             npuCfg,
	output logic             npuEnq,
	output logic             npuDeq,
	output logic             zeroEn,
	output logic             negativeEn,
	output logic             overflowEn,
	output logic [25:0]      offset,
	output logic [`XLEN-1:0] operand0,
	output logic [`XLEN-1:0] operand1
);
	import cpuPkg::*;

	ctrlWordT decCtrl;
	ctrlWordT issueCtrl;

	regReadIf rdIf ();

	decodeControl i_decode (
		.instruction (instruction),
		.ctrl        (decCtrl)
	);

	// Read addresses come straight from the decoder
	assign rdIf.addr0 = decCtrl.rdAddr0;
	assign rdIf.en0   = decCtrl.rdEn0;
	assign rdIf.addr1 = decCtrl.rdAddr1;
	assign rdIf.en1   = decCtrl.rdEn1;

	registerFile i_regFile (
		.clk    (clk),
		.rst    (rst),
		.wbEn   (wbEn),
		.wbAddr (wbAddr),
		.wbData (wbData),
		.rd     (rdIf)
	);

	issueRegister i_issue (
		.clk      (clk),
		.rst      (rst),
		.inValid  (instValid),
		.inReady  (instReady),
		.ctrlIn   (decCtrl),
		.op0In    (rdIf.data0),
		.op1In    (rdIf.data1),
		.outValid (issueValid),
		.outReady (issueReady),
		.ctrlOut  (issueCtrl),
		.op0Out   (operand0),
		.op1Out   (operand1)
	);

	// Same order as the struct fields
	assign {rdAddr0, rdEn0, rdAddr1, rdEn1, wrAddr, wrEn, exuOp, exuShift, aluOp, mduOp,
		fpuOp, branchOp, branch, jump, call, ret, aluImm, loadHigh, memValid, memWrite,
		memToReg, flush, halt, npuCfg, npuEnq, npuDeq, zeroEn, negativeEn, overflowEn,
		offset} = issueCtrl;

endmodule

//--- dv/decodeUnit_assert.sv
// Concurrent checks on reset and the issue handshake, bound into the decode stage top
`include "cpuDefines_defines.svh"

module decodeUnit_assert (
	input logic             clk,
	input logic             rst,
	input logic             instReady,
	input logic             issueValid,
	input logic             issueReady,
	input cpuPkg::ctrlWordT issueCtrl,
	input logic [`XLEN-1:0] operand0,
	input logic [`XLEN-1:0] operand1
);

	logic stalled;

	assign stalled = issueValid && !issueReady;

	// Issue register comes out of reset empty
	resetEmpty: assert property (@(posedge clk) rst |=> !issueValid)
		else $error("issueValid high in the cycle after reset");

	holdUnderStall: assert property (@(posedge clk) disable iff (rst)
		stalled |=> $stable(issueValid) && $stable(issueCtrl)
			&& $stable(operand0) && $stable(operand1))
		else $error("issue outputs changed while execute held them off");

	noAcceptWhenStalled: assert property (@(posedge clk) disable iff (rst)
		stalled |-> !instReady)
		else $error("instReady high while the issue register is stalled");

endmodule

//--- dv/decodeUnitTb.sv
// Self-checking testbench for the decode stage, used as the simulation top with assertions bound in
`include "cpuDefines_defines.svh"

module decodeUnitTb;
	import cpuPkg::*;

	localparam int PER_OPCODE  = 4;
	localparam int RANDOM_INST = 200;
	localparam int FWD_INST    = 16;
	localparam int STALL_INST  = 200;
	localparam int WB_WRITES   = 64;
	localparam int NUM_INST    = 30 * PER_OPCODE + RANDOM_INST + FWD_INST + STALL_INST;
	// Stall budget assumes ready low about one cycle in four
	localparam int TIMEOUT_CYCLES = 2 * NUM_INST + 4 * STALL_INST + WB_WRITES + 100;

	logic clk = 1'b0;
	logic rst;
	logic instValid, instReady, wbEn, issueValid, issueReady;
	logic [`XLEN-1:0] instruction, wbData, operand0, operand1;
	logic [`REGW-1:0] wbAddr, rdAddr0, rdAddr1, wrAddr;
	logic rdEn0, rdEn1, wrEn, mduOp, branch, jump, call, ret, aluImm, loadHigh;
	logic memValid, memWrite, memToReg, flush, halt, npuCfg, npuEnq, npuDeq;
	logic zeroEn, negativeEn, overflowEn;
	logic [1:0] exuOp;
	logic [4:0] exuShift;
	logic [3:0] aluOp;
	logic [2:0] fpuOp, branchOp;
	logic [25:0] offset;
	ctrlWordT issuedCtrl;

	logic [31:0] rngState = 32'd67;
	logic stallOn = 1'b0;
	int cycleCount = 0;
	logic [`XLEN-1:0] shadow [`NREGS];
	ctrlWordT ctrlQ[$];
	logic [`XLEN-1:0] op0Q[$];
	logic [`XLEN-1:0] op1Q[$];

	decodeUnit i_dut (.*);

	bind decodeUnit decodeUnit_assert i_assert (
		.clk        (clk),
		.rst        (rst),
		.instReady  (instReady),
		.issueValid (issueValid),
		.issueReady (issueReady),
		.issueCtrl  (issueCtrl),
		.operand0   (operand0),
		.operand1   (operand1)
	);

	assign issuedCtrl = {rdAddr0, rdEn0, rdAddr1, rdEn1, wrAddr, wrEn, exuOp, exuShift,
		aluOp, mduOp, fpuOp, branchOp, branch, jump, call, ret, aluImm, loadHigh, memValid,
		memWrite, memToReg, flush, halt, npuCfg, npuEnq, npuDeq, zeroEn, negativeEn,
		overflowEn, offset};

	always #5 clk = ~clk;

	function automatic logic [31:0] xorshift();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	// Expected control word, one opcode class at a time
	function automatic ctrlWordT refDecode(input logic [`XLEN-1:0] instr);
		ctrlWordT c;
		opcodeE op;
		logic flags;
		op = opcodeE'(instr[31:26]);
		flags = 1'b0;
		c = '0;
		c.rdAddr0 = instr[20:16];
		c.rdAddr1 = instr[15:11];
		c.wrAddr = instr[25:21];
		c.rdEn0 = 1'b1;
		c.rdEn1 = 1'b1;
		c.wrEn = 1'b1;
		c.exuOp = EXU_ALU;
		c.aluOp = aluOpE'(instr[29:26]);
		c.mduOp = instr[26];
		c.fpuOp = fpuOpE'(instr[28:26]);
		c.branchOp = branchOpE'(instr[25:23]);
		c.offset = instr[25:0];
		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: flags = 1'b1;
			OP_NOT: begin
				flags = 1'b1;
				c.rdEn1 = 1'b0;
			end
			OP_SLL, OP_SRL, OP_SRA: begin
				flags = 1'b1;
				c.rdEn1 = 1'b0;
				c.exuShift = instr[4:0];
			end
			OP_LHW: begin
				c.rdAddr0 = instr[25:21];
				c.rdEn1 = 1'b0;
				c.aluImm = 1'b1;
				c.loadHigh = 1'b1;
			end
			OP_LLW, OP_DEQD, OP_FLUSH, OP_BRANCH, OP_HALT, OP_ENQC: begin
				c.rdEn0 = 1'b0;
				c.rdEn1 = 1'b0;
				c.wrEn = op == OP_LLW || op == OP_DEQD;
				c.aluImm = op == OP_LLW || op == OP_ENQC;
				c.npuDeq = op == OP_DEQD;
				c.flush = op == OP_FLUSH;
				c.branch = op == OP_BRANCH;
				c.halt = op == OP_HALT;
				c.npuCfg = op == OP_ENQC;
				// Halt sits in the FPU encoding group
				c.exuOp = (op == OP_HALT) ? EXU_FPU : EXU_ALU;
			end
			OP_CALL, OP_RET: begin
				c.wrAddr = `REGW'(`LINK_REG);
				c.rdAddr0 = `REGW'(`LINK_REG);
				c.aluOp = ALU_ADD;
				c.memValid = 1'b1;
				c.call = op == OP_CALL;
				c.jump = op == OP_CALL;
				c.memWrite = op == OP_CALL;
				c.ret = op == OP_RET;
				c.rdEn1 = op == OP_RET;
				if (op == OP_RET)
					c.rdAddr1 = '0;
			end
			OP_LOAD, OP_STORE: begin
				c.aluOp = ALU_ADD;
				c.aluImm = 1'b1;
				c.memValid = 1'b1;
				c.memToReg = op == OP_LOAD;
				c.memWrite = op == OP_STORE;
				c.wrEn = op == OP_LOAD;
				c.rdAddr1 = (op == OP_LOAD) ? instr[20:16] : instr[25:21];
			end
			OP_MULT, OP_DIV: begin
				flags = 1'b1;
				c.exuOp = EXU_MDU;
			end
			OP_FADD, OP_FSUB, OP_FMULT, OP_FDIV, OP_FTOI, OP_ITOF, OP_SQRT: begin
				flags = 1'b1;
				c.exuOp = EXU_FPU;
				c.rdEn1 = op inside {OP_FADD, OP_FSUB, OP_FMULT, OP_FDIV};
			end
			OP_ENQD: begin
				c.wrEn = 1'b0;
				c.rdAddr0 = instr[25:21];
				c.rdEn1 = 1'b0;
				c.npuEnq = 1'b1;
			end
			default: ;
		endcase
		c.zeroEn = flags;
		c.negativeEn = flags;
		c.overflowEn = flags;
		return c;
	endfunction

	// Shadow value, with a write landing at this edge forwarded
	function automatic logic [`XLEN-1:0] expOperand(input logic en, input logic [`REGW-1:0] addr);
		logic [`XLEN-1:0] value;
		value = shadow[addr];
		if (wbEn && (wbAddr == addr))
			value = wbData;
		return en ? value : '0;
	endfunction

	function automatic logic [`XLEN-1:0] randomInst(input opcodeE op);
		return {op, 26'(xorshift())};
	endfunction

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic checkCtrl(input ctrlWordT got, input ctrlWordT exp);
		if (got !== exp)
			abortRun($sformatf("MISMATCH at %0t: control word %h, expected %h",
				$time, got, exp));
	endtask

	task automatic checkOperand(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp,
			input string name);
		if (got !== exp)
			abortRun($sformatf("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp));
	endtask

	// Holds the instruction until the stage takes it
	task automatic sendInst(input logic [`XLEN-1:0] instr, input logic doWb,
			input logic [`REGW-1:0] addr, input logic [`XLEN-1:0] data);
		logic taken;
		instValid = 1'b1;
		instruction = instr;
		wbEn = doWb;
		wbAddr = addr;
		wbData = data;
		do begin
			@(negedge clk);
			taken = instReady;
			@(posedge clk);
			#1;
			issueReady = stallOn ? ((xorshift() & 32'd3) != 32'd0) : 1'b1;
		end while (!taken);
		instValid = 1'b0;
		wbEn = 1'b0;
	endtask

	task automatic writeReg(input logic [`REGW-1:0] addr, input logic [`XLEN-1:0] data);
		wbEn = 1'b1;
		wbAddr = addr;
		wbData = data;
		@(posedge clk);
		#1;
		wbEn = 1'b0;
	endtask

	// Scoreboard checks what leaves before recording what enters
	always @(posedge clk) begin
		ctrlWordT exp;
		if (rst) begin
			for (int i = 0; i < `NREGS; i++)
				shadow[i] = '0;
		end else begin
			if (issueValid && issueReady) begin
				if (ctrlQ.size() == 0) begin
					abortRun("Instruction issued with no accepted instruction outstanding");
				end else begin
					checkCtrl(issuedCtrl, ctrlQ.pop_front());
					checkOperand(operand0, op0Q.pop_front(), "operand0");
					checkOperand(operand1, op1Q.pop_front(), "operand1");
				end
			end
			if (instValid && instReady) begin
				exp = refDecode(instruction);
				ctrlQ.push_back(exp);
				op0Q.push_back(expOperand(exp.rdEn0, exp.rdAddr0));
				op1Q.push_back(expOperand(exp.rdEn1, exp.rdAddr1));
			end
			if (wbEn)
				shadow[wbAddr] = wbData;
		end
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount > TIMEOUT_CYCLES)
			abortRun($sformatf("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
	end

	initial begin
		opcodeE op;
		opcodeE opList[$];
		logic [31:0] r;
		logic [`REGW-1:0] target;
		rst = 1'b1;
		instValid = 1'b0;
		instruction = '0;
		wbEn = 1'b0;
		wbAddr = '0;
		wbData = '0;
		issueReady = 1'b1;
		op = op.first();
		do begin
			opList.push_back(op);
			op = op.next();
		end while (op != op.first());
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		if (issueValid !== 1'b0)
			abortRun("issueValid was high right after reset");

		// Every opcode with random fields, registers still clear
		foreach (opList[i])
			repeat (PER_OPCODE)
				sendInst(randomInst(opList[i]), 1'b0, '0, '0);

		repeat (WB_WRITES)
			writeReg(`REGW'(xorshift()), xorshift());
		repeat (RANDOM_INST) begin
			r = xorshift();
			sendInst(randomInst(opList[r % opList.size()]), r[31], `REGW'(r >> 8), xorshift());
		end

		// Both sources read the register written in the same cycle
		repeat (FWD_INST) begin
			target = `REGW'(xorshift());
			sendInst({OP_SUB, `REGW'(xorshift()), target, target, 11'(xorshift())},
				1'b1, target, xorshift());
		end

		stallOn = 1'b1;
		repeat (STALL_INST) begin
			r = xorshift();
			sendInst(randomInst(opList[r % opList.size()]), r[31], `REGW'(r >> 8), xorshift());
		end
		stallOn = 1'b0;
		issueReady = 1'b1;
		while (ctrlQ.size() != 0)
			@(posedge clk);
		repeat (2) @(posedge clk);
		#1;
		if (issueValid !== 1'b0) begin
			abortRun("issueValid still high after every instruction was issued");
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

//--- all.f
+incdir+src
src/cpuPkg.sv
src/regReadIf.sv
src/decodeControl.sv
src/registerFile.sv
src/issueRegister.sv
src/decodeUnit.sv
dv/decodeUnit_assert.sv
dv/decodeUnitTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= decodeUnitTb
FILELIST  ?= all.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
